// File: src/cmp_rx_settings.svh
`ifndef CMP_RX_SETTINGS_SVH
`define CMP_RX_SETTINGS_SVH

//----------------------------------------------------------------------
// Link word and frame geometry
//----------------------------------------------------------------------
`define CMP_WORD_W      16      // One deserialized link word
`define CMP_FRAME_W     48      // Three data words per frame

//----------------------------------------------------------------------
// K characters in the low byte of a frame marker
//----------------------------------------------------------------------
`define CMP_K_EOF       8'hBC   // Ordinary end of frame marker
`define CMP_K_TRIG      8'hFC   // Marker that also fires the latency trigger

//----------------------------------------------------------------------
// Link health thresholds
//----------------------------------------------------------------------
`define CMP_GOOD_FRAMES 15      // Clean frames before link good
`define CMP_ERR_SAT     254     // Link drop counter stops here
`define CMP_BAD_THRESH  128     // Drops at which link is declared bad

// Symbol error counters stop one below all ones
`define CMP_SYM_SAT     65534

`endif

// File: src/cmp_rx_pkg.sv
`include "cmp_rx_settings.svh"

package cmp_rx_pkg;

  // One word as delivered by the 8b10b decoder
  typedef logic [`CMP_WORD_W-1:0]  cmp_word_t;

  // Per byte flag pair, bit 0 is the low byte
  typedef logic [1:0]              cmp_flag2_t;

  // Assembled payload {word 3, word 2, word 1}
  typedef logic [`CMP_FRAME_W-1:0] cmp_frame_t;

  // One bit per frame slot, index equals slot number
  typedef logic [3:0]              cmp_slots_t;

  // Link drop count
  typedef logic [7:0]              cmp_errcnt_t;

  // Not-in-table or disparity error count
  typedef logic [15:0]             cmp_symcnt_t;

endpackage

// File: src/cmp_frame_capture.sv
`include "cmp_rx_settings.svh"

module cmp_frame_capture import cmp_rx_pkg::*; (
  input  logic        CMP_RX_CLK160,
  input  logic        cmp_rx_resetdone,
  input  cmp_word_t   rx_data,
  input  cmp_flag2_t  rx_isk,
  input  cmp_flag2_t  rx_notintable,
  input  logic        rx_lossofsync,
  input  logic        rx_sync_done,
  input  logic        ttc_resync,
  output logic        link_clear,     // Sync clear for the whole receiver
  output cmp_slots_t  slot,           // Slot phase, one hot in steady state
  output cmp_slots_t  slot_health,    // Per slot word quality
  output logic        frame_end,      // Slot 3 strobe
  output logic        frame_gap,      // No slot active
  output cmp_frame_t  asm_data,
  output cmp_word_t   asm_kchar,
  output logic        asm_trig,
  output logic [3:1]  asm_nonzero
);

  logic      sync_match;    // Frame K word on the input
  logic      trig_match;    // K word with FC low byte
  logic      marker_ok;     // Low byte is a legal frame marker
  logic      word_clean;    // Decoder flags clean
  logic      data_ok;       // Clean data word, no K bits

  cmp_word_t w0_reg;        // K word from slot 0
  cmp_word_t w1_reg;        // First data word
  cmp_word_t w2_reg;        // Second data word
  logic      nz1_reg;
  logic      nz2_reg;
  logic      trig_reg;

  //--------------------------------------------------------------------
  // Input decode
  //--------------------------------------------------------------------
  assign link_clear = !rx_sync_done || ttc_resync;

  assign sync_match = (rx_isk == 2'b01);                 // Only low byte is K
  assign trig_match = sync_match && (rx_data[7:0] == `CMP_K_TRIG);
  assign marker_ok  = (rx_data[7:0] == `CMP_K_EOF) ||
                      (rx_data[7:0] == `CMP_K_TRIG);
  assign word_clean = !rx_lossofsync && (rx_notintable == 2'b00);
  assign data_ok    = word_clean && (rx_isk == 2'b00);

  //--------------------------------------------------------------------
  // Slot shift chain
  //--------------------------------------------------------------------
  // K word lands in slot 1 next cycle, then 2, 3 and back to 0
  always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
    if (!cmp_rx_resetdone) begin
      slot <= '0;
    end else if (link_clear) begin
      slot <= '0;
    end else begin
      slot <= {slot[2], slot[1], sync_match, slot[3]};
    end
  end

  //--------------------------------------------------------------------
  // Word capture and health scoring
  //--------------------------------------------------------------------
  always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
    if (!cmp_rx_resetdone) begin
      w0_reg      <= '0;
      w1_reg      <= '0;
      w2_reg      <= '0;
      nz1_reg     <= 1'b0;
      nz2_reg     <= 1'b0;
      trig_reg    <= 1'b0;
      slot_health <= '0;
    end else if (link_clear) begin
      w0_reg      <= '0;
      w1_reg      <= '0;
      w2_reg      <= '0;
      nz1_reg     <= 1'b0;
      nz2_reg     <= 1'b0;
      trig_reg    <= 1'b0;
      slot_health <= '0;
    end else if (slot[0]) begin
      // Slot 0 coincides with the K word of the next frame
      w0_reg         <= rx_data;
      trig_reg       <= trig_match;
      slot_health[0] <= word_clean && sync_match && marker_ok;
    end else if (slot[1]) begin
      w1_reg         <= rx_data;
      nz1_reg        <= |rx_data;
      slot_health[1] <= data_ok && !slot[2] && !slot[3];  // Marker spacing check
    end else if (slot[2]) begin
      w2_reg         <= rx_data;
      nz2_reg        <= |rx_data;
      slot_health[2] <= data_ok && !slot[3];
    end else if (slot[3]) begin
      slot_health[3] <= data_ok;                         // Word 3 goes straight out
    end else begin
      slot_health <= '0;    // Missing marker, monitor sees a bad frame
    end
  end

  //--------------------------------------------------------------------
  // Assembled frame towards the buffer
  //--------------------------------------------------------------------
  assign frame_end   = slot[3];
  assign frame_gap   = (slot == '0);
  assign asm_data    = {rx_data, w2_reg, w1_reg};   // Word 3 taken live
  assign asm_kchar   = w0_reg;
  assign asm_trig    = trig_reg;
  assign asm_nonzero = {|rx_data, nz2_reg, nz1_reg};

endmodule

// File: src/cmp_frame_buffer.sv
module cmp_frame_buffer import cmp_rx_pkg::*; (
  input  logic        CMP_RX_CLK160,
  input  logic        cmp_rx_resetdone,
  input  logic        link_clear,
  input  logic        frame_end,
  input  logic        frame_gap,
  input  cmp_frame_t  asm_data,
  input  cmp_word_t   asm_kchar,
  input  logic        asm_trig,
  input  logic [3:1]  asm_nonzero,
  output cmp_frame_t  rcv_data,       // Payload of the last frame
  output cmp_word_t   rcv_kchar,      // K word that opened it
  output logic        ltncy_trig,     // FC marker seen
  output logic [3:1]  nonzero_word    // One flag per data word
);

  //--------------------------------------------------------------------
  // Output registers
  //--------------------------------------------------------------------
  // Whole frame loads at once on the slot 3 edge
  // Holds across slots 0 to 2 of the next frame
  always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
    if (!cmp_rx_resetdone) begin
      rcv_data     <= '0;
      rcv_kchar    <= '0;
      ltncy_trig   <= 1'b0;
      nonzero_word <= '0;
    end else if (link_clear) begin
      rcv_data     <= '0;
      rcv_kchar    <= '0;
      ltncy_trig   <= 1'b0;
      nonzero_word <= '0;
    end else if (frame_end) begin
      rcv_data     <= asm_data;
      rcv_kchar    <= asm_kchar;
      ltncy_trig   <= asm_trig;
      nonzero_word <= asm_nonzero;
    end else if (frame_gap) begin
      // Stream broke, drop the stale frame
      rcv_data     <= '0;
      rcv_kchar    <= '0;
      ltncy_trig   <= 1'b0;
      nonzero_word <= '0;
    end
  end

endmodule

// File: src/cmp_link_monitor.sv
`include "cmp_rx_settings.svh"

module cmp_link_monitor import cmp_rx_pkg::*; (
  input  logic        CMP_RX_CLK160,
  input  logic        cmp_rx_resetdone,
  input  logic        link_clear,
  input  cmp_slots_t  slot_health,
  input  logic        frame_end,
  output logic        link_good,      // Link alive after a run of clean frames
  output logic        link_had_err,   // Link failed at least once or never came up
  output logic        link_bad,       // Too many drops
  output cmp_errcnt_t errcount        // Saturating drop count
);

  localparam int GOOD_W = $clog2(`CMP_GOOD_FRAMES + 1);

  logic              mon_rst;         // Last frame was not clean
  logic [GOOD_W-1:0] good_cnt;        // Clean frames since last failure
  logic              link_err;        // Sticky drop flag
  logic              link_went_down;  // Was good, now failing

  assign link_went_down = link_good && mon_rst;

  //--------------------------------------------------------------------
  // Frame quality and qualification counter
  //--------------------------------------------------------------------
  always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
    if (!cmp_rx_resetdone) begin
      mon_rst   <= 1'b1;              // Link counts as down out of reset
      good_cnt  <= '0;
      link_good <= 1'b0;
    end else if (link_clear) begin
      mon_rst   <= 1'b1;
      good_cnt  <= '0;
      link_good <= 1'b0;
    end else begin
      mon_rst <= (slot_health != 4'hF);    // Any slot failed
      if (mon_rst) begin
        good_cnt <= '0;
      end else if (!link_good && frame_end) begin
        good_cnt <= good_cnt + 1'b1;       // Frozen once link is good
      end
      // Rises one cycle after the final counted frame
      link_good <= !mon_rst && (good_cnt == GOOD_W'(`CMP_GOOD_FRAMES));
    end
  end

  //--------------------------------------------------------------------
  // Drop tracking
  //--------------------------------------------------------------------
  always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
    if (!cmp_rx_resetdone) begin
      link_err <= 1'b0;
      errcount <= '0;
    end else if (link_clear) begin
      link_err <= 1'b0;
      errcount <= '0;
    end else begin
      if (link_went_down) begin
        link_err <= 1'b1;                  // Stays until next clear
      end
      if (link_went_down && (errcount != cmp_errcnt_t'(`CMP_ERR_SAT))) begin
        errcount <= errcount + 1'b1;
      end
    end
  end

  assign link_had_err = link_err || mon_rst;   // Also high while still qualifying
  assign link_bad     = (errcount >= cmp_errcnt_t'(`CMP_BAD_THRESH));

endmodule

// File: src/cmp_symbol_err_counters.sv
`include "cmp_rx_settings.svh"

module cmp_symbol_err_counters import cmp_rx_pkg::*; (
  input  logic        CMP_RX_CLK160,
  input  logic        cmp_rx_resetdone,
  input  logic        link_clear,
  input  cmp_slots_t  slot,
  input  cmp_flag2_t  rx_notintable,
  input  cmp_flag2_t  rx_disperr,
  output cmp_symcnt_t notintablecount,
  output cmp_symcnt_t disperrcount
);

  logic in_frame;       // Some slot active
  logic nit_hit;
  logic disp_hit;

  assign in_frame = |slot;
  // Either byte flagged counts once per word
  assign nit_hit  = in_frame && (rx_notintable != 2'b00) &&
                    (notintablecount != cmp_symcnt_t'(`CMP_SYM_SAT));
  assign disp_hit = in_frame && (rx_disperr != 2'b00) &&
                    (disperrcount != cmp_symcnt_t'(`CMP_SYM_SAT));

  //--------------------------------------------------------------------
  // Saturating counters
  //--------------------------------------------------------------------
  always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
    if (!cmp_rx_resetdone) begin
      notintablecount <= '0;
      disperrcount    <= '0;
    end else if (link_clear) begin
      notintablecount <= '0;
      disperrcount    <= '0;
    end else begin
      if (nit_hit) begin
        notintablecount <= notintablecount + 1'b1;
      end
      if (disp_hit) begin
        disperrcount <= disperrcount + 1'b1;
      end
    end
  end

endmodule

// File: src/cmp_fiber_rx.sv
module cmp_fiber_rx import cmp_rx_pkg::*; (
  input  logic        CMP_RX_CLK160,
  input  logic        cmp_rx_resetdone,
  // Deserializer side
  input  cmp_word_t   rx_data,
  input  cmp_flag2_t  rx_isk,
  input  cmp_flag2_t  rx_notintable,
  input  cmp_flag2_t  rx_disperr,
  input  logic        rx_lossofsync,
  input  logic        rx_sync_done,
  input  logic        ttc_resync,
  // Frame outputs
  output cmp_frame_t  rcv_data,
  output cmp_word_t   rcv_kchar,
  output logic        ltncy_trig,
  output logic [3:1]  nonzero_word,
  // Link status
  output logic        link_good,
  output logic        link_had_err,
  output logic        link_bad,
  output cmp_errcnt_t errcount,
  output cmp_symcnt_t notintablecount,
  output cmp_symcnt_t disperrcount
);

  logic        link_clear;
  cmp_slots_t  slot;
  cmp_slots_t  slot_health;
  logic        frame_end;
  logic        frame_gap;
  cmp_frame_t  asm_data;
  cmp_word_t   asm_kchar;
  logic        asm_trig;
  logic [3:1]  asm_nonzero;

  //--------------------------------------------------------------------
  // Alignment and capture
  //--------------------------------------------------------------------
  cmp_frame_capture u_capture (
    .CMP_RX_CLK160    (CMP_RX_CLK160),
    .cmp_rx_resetdone (cmp_rx_resetdone),
    .rx_data          (rx_data),
    .rx_isk           (rx_isk),
    .rx_notintable    (rx_notintable),
    .rx_lossofsync    (rx_lossofsync),
    .rx_sync_done     (rx_sync_done),
    .ttc_resync       (ttc_resync),
    .link_clear       (link_clear),
    .slot             (slot),
    .slot_health      (slot_health),
    .frame_end        (frame_end),
    .frame_gap        (frame_gap),
    .asm_data         (asm_data),
    .asm_kchar        (asm_kchar),
    .asm_trig         (asm_trig),
    .asm_nonzero      (asm_nonzero)
  );

  cmp_frame_buffer u_buffer (
    .CMP_RX_CLK160    (CMP_RX_CLK160),
    .cmp_rx_resetdone (cmp_rx_resetdone),
    .link_clear       (link_clear),
    .frame_end        (frame_end),
    .frame_gap        (frame_gap),
    .asm_data         (asm_data),
    .asm_kchar        (asm_kchar),
    .asm_trig         (asm_trig),
    .asm_nonzero      (asm_nonzero),
    .rcv_data         (rcv_data),
    .rcv_kchar        (rcv_kchar),
    .ltncy_trig       (ltncy_trig),
    .nonzero_word     (nonzero_word)
  );

  //--------------------------------------------------------------------
  // Health and error statistics
  //--------------------------------------------------------------------
  cmp_link_monitor u_monitor (
    .CMP_RX_CLK160    (CMP_RX_CLK160),
    .cmp_rx_resetdone (cmp_rx_resetdone),
    .link_clear       (link_clear),
    .slot_health      (slot_health),
    .frame_end        (frame_end),
    .link_good        (link_good),
    .link_had_err     (link_had_err),
    .link_bad         (link_bad),
    .errcount         (errcount)
  );

  cmp_symbol_err_counters u_symerr (
    .CMP_RX_CLK160    (CMP_RX_CLK160),
    .cmp_rx_resetdone (cmp_rx_resetdone),
    .link_clear       (link_clear),
    .slot             (slot),
    .rx_notintable    (rx_notintable),
    .rx_disperr       (rx_disperr),
    .notintablecount  (notintablecount),
    .disperrcount     (disperrcount)
  );

endmodule

// File: tests/cmp_link_checker.sv
`include "cmp_rx_settings.svh"

module cmp_link_checker import cmp_rx_pkg::*; (
  input logic        CMP_RX_CLK160,
  input logic        cmp_rx_resetdone,
  input logic        link_clear,
  input logic        mon_rst,
  input logic        link_good,
  input logic        link_bad,
  input cmp_errcnt_t errcount
);

  timeunit 1ns;
  timeprecision 1ps;

  int fail_cnt = 0;     // Seen by the testbench

  // Link bad only past the drop threshold
  a_bad_thresh: assert property (@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
    link_bad |-> (errcount >= cmp_errcnt_t'(`CMP_BAD_THRESH)))
    else begin $error("link_bad with errcount %0d", errcount); fail_cnt++; end

  // Failing frame takes link good down on the next edge
  a_good_drop: assert property (@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
    mon_rst |=> !link_good)
    else begin $error("link_good stayed high after mon_rst"); fail_cnt++; end

  a_clear: assert property (@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
    link_clear |=> (errcount == '0) && !link_good)
    else begin $error("link_clear left state behind"); fail_cnt++; end

endmodule

bind cmp_link_monitor cmp_link_checker u_link_checker (
  .CMP_RX_CLK160    (CMP_RX_CLK160),
  .cmp_rx_resetdone (cmp_rx_resetdone),
  .link_clear       (link_clear),
  .mon_rst          (mon_rst),
  .link_good        (link_good),
  .link_bad         (link_bad),
  .errcount         (errcount)
);

// File: tests/tb_cmp_fiber_rx.sv
`include "cmp_rx_settings.svh"

module tb_cmp_fiber_rx import cmp_rx_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_QUAL    = 24;                         // Frames allowed for link up
  localparam int N_DROPS     = `CMP_BAD_THRESH;
  localparam int STIM_CYCLES = 400 + N_DROPS * (5 + 4 * MAX_QUAL);

  logic        CMP_RX_CLK160 = 1'b0;
  logic        cmp_rx_resetdone;
  cmp_word_t   rx_data;
  cmp_flag2_t  rx_isk;
  cmp_flag2_t  rx_notintable;
  cmp_flag2_t  rx_disperr;
  logic        rx_lossofsync;
  logic        rx_sync_done;
  logic        ttc_resync;
  cmp_frame_t  rcv_data;
  cmp_word_t   rcv_kchar;
  logic        ltncy_trig;
  logic [3:1]  nonzero_word;
  logic        link_good;
  logic        link_had_err;
  logic        link_bad;
  cmp_errcnt_t errcount;
  cmp_symcnt_t notintablecount;
  cmp_symcnt_t disperrcount;

  int          err_cnt = 0;
  int          seed_val;
  int          exp_nit;
  int          exp_disp;
  logic [3:0]  sym_nit;
  logic [3:0]  sym_disp;
  logic        aligned = 1'b0;    // Previous frame ran back to back
  logic [67:0] exp_q [$];         // {nonzero, trig, kchar, data}
  time         due_q [$];         // Falling edge at which each entry is due
  logic [67:0] exp_frame;

  cmp_fiber_rx u_cmp_fiber_rx (.*);

  always #5 CMP_RX_CLK160 = ~CMP_RX_CLK160;

  //--------------------------------------------------------------------
  // Reference model and helpers
  //--------------------------------------------------------------------
  function automatic logic [67:0] frame_expect(cmp_word_t k, cmp_word_t w1, cmp_word_t w2,
                                               cmp_word_t w3);
    logic [67:0] r;
    r[47:0]  = {w3, w2, w1};                 // Word 1 in the low bits
    r[63:48] = k;
    r[64]    = (k[7:0] == `CMP_K_TRIG);
    r[67:65] = {w3 != '0, w2 != '0, w1 != '0};
    return r;
  endfunction

  task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
    if (expected !== actual) begin
      err_cnt++;
      $display("ERR %s expected %0h actual %0h", name, expected, actual);
      $display("=== FAIL ===");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic fail_run(string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "Run aborted");
  endtask

  // Drives on the current falling edge and returns on the next one
  task automatic drive_word(cmp_word_t d, cmp_flag2_t isk, cmp_flag2_t nit, cmp_flag2_t disp);
    rx_data       = d;
    rx_isk        = isk;
    rx_notintable = nit;
    rx_disperr    = disp;
    @(negedge CMP_RX_CLK160);
  endtask

  task automatic send_frame(logic [3:0] nit_sel, logic [3:0] disp_sel);
    cmp_word_t k;
    cmp_word_t w [1:3];
    k[15:8] = 8'($urandom);
    k[7:0]  = $urandom_range(1) ? `CMP_K_TRIG : `CMP_K_EOF;
    for (int i = 1; i <= 3; i++) begin
      w[i] = 16'($urandom);
      if ($urandom_range(3) == 0) w[i] = '0;   // Exercise a cleared nonzero flag
    end
    drive_word(k,    2'b01, {1'b0, nit_sel[0]}, {1'b0, disp_sel[0]});
    drive_word(w[1], 2'b00, {1'b0, nit_sel[1]}, {1'b0, disp_sel[1]});
    drive_word(w[2], 2'b00, {1'b0, nit_sel[2]}, {1'b0, disp_sel[2]});
    if (aligned) begin                       // K word only captured in slot 0
      exp_q.push_back(frame_expect(k, w[1], w[2], w[3]));
      due_q.push_back($time + 10);
    end
    drive_word(w[3], 2'b00, {1'b0, nit_sel[3]}, {1'b0, disp_sel[3]});
    aligned = 1'b1;
  endtask

  task automatic send_idle(cmp_flag2_t nit, cmp_flag2_t disp);
    drive_word('0, 2'b00, nit, disp);
    aligned = 1'b0;
  endtask

  task automatic pulse_resync();
    ttc_resync = 1'b1;
    send_idle(2'b00, 2'b00);
    ttc_resync = 1'b0;
  endtask

  task automatic qualify_link();
    int n;
    n = 0;
    while (!link_good && n < MAX_QUAL) begin
      send_frame(4'b0, 4'b0);
      n++;
    end
    if (!link_good) fail_run("Link did not come up within the allowed frames");
  endtask

  //--------------------------------------------------------------------
  // Frame comparison one cycle after each word 3
  //--------------------------------------------------------------------
  always @(negedge CMP_RX_CLK160) begin
    if (due_q.size() > 0 && due_q[0] == $time) begin
      void'(due_q.pop_front());
      exp_frame = exp_q.pop_front();
      check_value("frame_data", exp_frame[47:0], rcv_data);
      check_value("frame_kchar", exp_frame[63:48], rcv_kchar);
      check_value("frame_trig", exp_frame[64], ltncy_trig);
      check_value("frame_nonzero", exp_frame[67:65], nonzero_word);
    end
  end

  initial begin
    wait (u_cmp_fiber_rx.u_monitor.u_link_checker.fail_cnt != 0);
    fail_run("A link monitor assertion failed");
  end

  initial begin
    #(STIM_CYCLES * 2 * 10);
    fail_run("Watchdog expired before the tests completed");
  end

  //--------------------------------------------------------------------
  // Main sequence
  //--------------------------------------------------------------------
  initial begin
    seed_val = $urandom(32'h5e9d);
    cmp_rx_resetdone = 1'b0;
    rx_data = '0;
    rx_isk = '0;
    rx_notintable = '0;
    rx_disperr = '0;
    rx_lossofsync = 1'b0;
    rx_sync_done = 1'b1;
    ttc_resync = 1'b0;
    repeat (3) @(negedge CMP_RX_CLK160);
    cmp_rx_resetdone = 1'b1;
    // Assembly and qualification from reset
    repeat (18) send_frame(4'b0, 4'b0);
    check_value("qual_link_good", 1, link_good);
    check_value("qual_had_err", 0, link_had_err);
    // Gap between frames
    send_idle(2'b00, 2'b00);
    send_idle(2'b00, 2'b00);
    check_value("gap_data", 0, rcv_data);
    check_value("gap_kchar", 0, rcv_kchar);
    check_value("gap_trig", 0, ltncy_trig);
    check_value("gap_nonzero", 0, nonzero_word);
    send_frame(4'b0, 4'b0);
    check_value("gap_link_good", 0, link_good);
    // Too few frames after a clear
    pulse_resync();
    repeat (10) send_frame(4'b0, 4'b0);
    check_value("clear_link_good", 0, link_good);
    // Link drops up to the bad threshold
    for (int d = 1; d <= N_DROPS; d++) begin
      qualify_link();
      check_value("drop_had_err", d > 1, link_had_err);   // Sticky once the link is up again
      send_idle(2'b00, 2'b00);
      send_frame(4'b0, 4'b0);
      check_value("drop_count", d, errcount);
      if (d == N_DROPS - 1) check_value("bad_below_thresh", 0, link_bad);
    end
    check_value("bad_at_thresh", 1, link_bad);
    // Symbol errors on data words only with the K slot left clean
    qualify_link();
    exp_nit  = notintablecount;
    exp_disp = disperrcount;
    repeat (4) begin
      sym_nit  = 4'($urandom_range(7)) << 1;
      sym_disp = 4'($urandom_range(7)) << 1;
      exp_nit  += $countones(sym_nit);
      exp_disp += $countones(sym_disp);
      send_frame(sym_nit, sym_disp);
    end
    check_value("sym_nit", exp_nit, notintablecount);
    check_value("sym_disp", exp_disp, disperrcount);
    send_idle(2'b00, 2'b00);                 // Trailing slot 0 word
    repeat (5) send_idle(2'b11, 2'b11);      // No slot active now
    check_value("idle_nit", exp_nit, notintablecount);
    check_value("idle_disp", exp_disp, disperrcount);
    qualify_link();
    pulse_resync();
    check_value("resync_nit", 0, notintablecount);
    check_value("resync_disp", 0, disperrcount);
    check_value("resync_errcount", 0, errcount);
    check_value("resync_link_good", 0, link_good);
    if (err_cnt == 0) $display("=== PASS ===");
    else $display("=== FAIL ===");
    $finish;
  end

endmodule

// File: cmp_fiber_rx.f
+incdir+src
src/cmp_rx_pkg.sv
src/cmp_frame_capture.sv
src/cmp_frame_buffer.sv
src/cmp_link_monitor.sv
src/cmp_symbol_err_counters.sv
src/cmp_fiber_rx.sv
tests/cmp_link_checker.sv
tests/tb_cmp_fiber_rx.sv

// File: Bender.yml
package:
  name: cmp_fiber_rx

sources:
  - include_dirs:
      - src
    files:
      - src/cmp_rx_pkg.sv
      - src/cmp_frame_capture.sv
      - src/cmp_frame_buffer.sv
      - src/cmp_link_monitor.sv
      - src/cmp_symbol_err_counters.sv
      - src/cmp_fiber_rx.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/cmp_link_checker.sv
      - tests/tb_cmp_fiber_rx.sv
